//--- dv/mem_stage_testdata.txt
# test stall flush rd_we rd_addr rd_mem_data mem_addr mem_op csr_we csr_addr csr_data
# wb_off wb_we wb_addr wb_data csr_off csr_we csr_addr csr_data (offsets decimal, rest hex)
1 00 00 0 00 deadbeef 00000040 1c 0 000 00000000 2 0 00 00000000 1 0 000 00000000
1 00 00 1 05 00000000 00000040 14 0 000 00000000 2 1 05 deadbeef 1 0 000 00000000
2 00 00 0 00 00000011 00000080 18 0 000 00000000 2 0 00 00000000 1 0 000 00000000
2 00 00 0 00 12345682 00000081 18 0 000 00000000 2 0 00 00000000 1 0 000 00000000
2 00 00 0 00 cafea5f3 00000082 1a 0 000 00000000 2 0 00 00000000 1 0 000 00000000
2 00 00 1 06 00000000 00000081 10 0 000 00000000 2 1 06 ffffff82 1 0 000 00000000
2 00 00 1 07 00000000 00000081 11 0 000 00000000 2 1 07 00000082 1 0 000 00000000
2 00 00 1 08 00000000 00000082 12 0 000 00000000 2 1 08 ffffa5f3 1 0 000 00000000
2 00 00 1 09 00000000 00000082 13 0 000 00000000 2 1 09 0000a5f3 1 0 000 00000000
2 00 00 1 0a 00000000 00000080 14 0 000 00000000 2 1 0a a5f38211 1 0 000 00000000
2 00 00 1 0b 00000000 00000080 10 0 000 00000000 2 1 0b 00000011 1 0 000 00000000
3 00 00 1 0c 13572468 00000000 00 0 000 00000000 2 1 0c 13572468 1 0 000 00000000
3 00 00 0 0d 24681357 00000000 00 0 000 00000000 2 0 00 00000000 1 0 000 00000000
4 00 00 0 00 00000000 00000000 00 1 305 00001000 2 0 00 00000000 1 1 305 00001000
5 00 08 0 00 0badf00d 00000040 1c 0 000 00000000 2 0 00 00000000 1 0 000 00000000
5 00 08 1 0d 99999999 00000000 00 1 342 00000007 2 0 00 00000000 1 0 000 00000000
5 00 00 1 0e 00000000 00000040 14 0 000 00000000 2 1 0e deadbeef 1 0 000 00000000
6 00 00 1 0e 11111111 00000000 00 1 300 aaaa0001 2 1 0e 11111111 1 1 300 aaaa0001
6 00 00 1 0f 22222222 00000000 00 1 301 bbbb0002 4 1 0f 22222222 1 1 301 bbbb0002
6 38 00 0 00 00000000 00000000 00 0 000 00000000 1 1 0e 11111111 1 1 301 bbbb0002
6 38 00 0 00 00000000 00000000 00 0 000 00000000 1 1 0e 11111111 1 1 301 bbbb0002
6 00 00 0 00 00000000 00000000 00 0 000 00000000 2 0 00 00000000 1 0 000 00000000
6 00 00 1 10 33333333 00000000 00 0 000 00000000 2 1 10 33333333 1 0 000 00000000
6 08 00 1 11 44444444 00000000 00 0 000 00000000 2 0 00 00000000 1 0 000 00000000
6 00 00 1 11 44444444 00000000 00 0 000 00000000 2 1 11 44444444 1 0 000 00000000

//--- dv/tb_mem_stage.sv
`timescale 1ns/1ps

module tb_mem_stage;

    localparam int MAX_CYC     = 128;
    localparam int MAX_TESTS   = 8;
    localparam int DRAIN_LIMIT = 16;

    logic                    clk;
    logic                    reset_i;
    mem_stage_pkg::ex_ls_t   ex_i;
    logic [5:0]              stall_i;
    logic [4:0]              flush_i;
    mem_stage_pkg::wb_t      wb_o;
    mem_stage_pkg::csr_wr_t  csr_wr_o;

    // Expected outputs, indexed by the cycle in which they must show.
    logic                    exp_wb_v [MAX_CYC];
    mem_stage_pkg::wb_t      exp_wb [MAX_CYC];
    int                      exp_wb_test [MAX_CYC];
    logic                    exp_csr_v [MAX_CYC];
    mem_stage_pkg::csr_wr_t  exp_csr [MAX_CYC];
    int                      exp_csr_test [MAX_CYC];
    logic                    test_used [MAX_TESTS];
    int                      test_last [MAX_TESTS];
    int                      test_errs [MAX_TESTS];
    int                      errors;
    int                      tests_passed;
    int                      tests_failed;

    mem_stage #(
        .DMEM_DEPTH_WORDS (256)
    ) u_dut (
        .clk      (clk),
        .reset_i  (reset_i),
        .ex_i     (ex_i),
        .stall_i  (stall_i),
        .flush_i  (flush_i),
        .wb_o     (wb_o),
        .csr_wr_o (csr_wr_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act, input int test);
        assert (exp === act) else begin
            $display("Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
            errors++;
            test_errs[test]++;
        end
    endtask

    task automatic finish_test(input int t);
        if (test_errs[t] == 0) begin
            tests_passed++;
            $display("Test %0d finished: ok", t);
        end else begin
            tests_failed++;
            $display("Test %0d finished: %0d errors", t, test_errs[t]);
        end
    endtask

    task automatic check_cycle(input int c);
        int t;
        if (exp_wb_v[c]) begin
            t = exp_wb_test[c];
            if (exp_wb[c].we) begin
                assert (wb_o.we === 1'b1) else begin
                    $display("Write-back to x%0d did not happen at %0t ns",
                             exp_wb[c].addr, $time);
                    errors++;
                    test_errs[t]++;
                end
                check_value("wb_o.addr", 32'(exp_wb[c].addr), 32'(wb_o.addr), t);
                check_value("wb_o.data", exp_wb[c].data, wb_o.data, t);
            end else begin
                check_value("wb_o.we", 32'(exp_wb[c].we), 32'(wb_o.we), t);
            end
        end
        if (exp_csr_v[c]) begin
            t = exp_csr_test[c];
            check_value("csr_wr_o.we", 32'(exp_csr[c].we), 32'(csr_wr_o.we), t);
            if (exp_csr[c].we) begin
                check_value("csr_wr_o.waddr", 32'(exp_csr[c].waddr), 32'(csr_wr_o.waddr), t);
                check_value("csr_wr_o.wdata", exp_csr[c].wdata, csr_wr_o.wdata, t);
            end
        end
        for (int i = 0; i < MAX_TESTS; i++) begin
            if (test_used[i] && test_last[i] == c) begin
                finish_test(i);
            end
        end
    endtask

    initial begin
        int                     fd;
        int                     n;
        int                     test;
        int                     wb_off;
        int                     csr_off;
        int                     cyc;
        int                     last_slot;
        int                     guard;
        string                  line;
        logic [5:0]             st;
        logic [4:0]             fl;
        logic                   rd_we;
        logic [4:0]             rd_addr;
        logic [31:0]            rd_data;
        logic [31:0]            addr;
        logic [4:0]             op;
        logic                   cwe;
        logic [11:0]            caddr;
        logic [31:0]            cdata;
        logic                   e_wb_we;
        logic [4:0]             e_wb_addr;
        logic [31:0]            e_wb_data;
        logic                   e_cwe;
        logic [11:0]            e_caddr;
        logic [31:0]            e_cdata;
        mem_stage_pkg::ex_ls_t  bundle;

        void'($urandom(32'hb36eeefd));
        reset_i  = 1'b1;
        ex_i     = '0;
        stall_i  = '0;
        flush_i  = '0;
        errors   = 0;
        tests_passed = 0;
        tests_failed = 0;
        for (int i = 0; i < MAX_CYC; i++) begin
            exp_wb_v[i]  = 1'b0;
            exp_csr_v[i] = 1'b0;
        end
        for (int i = 0; i < MAX_TESTS; i++) begin
            test_used[i] = 1'b0;
            test_last[i] = 0;
            test_errs[i] = 0;
        end

        fd = $fopen("dv/mem_stage_testdata.txt", "r");
        if (fd == 0) begin
            $display("Could not open the test data file");
            $display("SIMULATION FAILED");
            $finish;
        end else begin
            repeat (3) @(posedge clk);
            reset_i <= 1'b0;
            cyc       = 0;
            last_slot = -1;

            while (!$feof(fd)) begin
                n = $fgets(line, fd);
                if (n == 0 || line.len() < 2 || line.getc(0) == 8'h23) begin
                    continue;
                end
                n = $sscanf(line, "%d %h %h %h %h %h %h %h %h %h %h %d %h %h %h %d %h %h %h",
                            test, st, fl, rd_we, rd_addr, rd_data, addr, op, cwe, caddr,
                            cdata, wb_off, e_wb_we, e_wb_addr, e_wb_data, csr_off, e_cwe,
                            e_caddr, e_cdata);
                if (n != 19 || test < 0 || test >= MAX_TESTS) begin
                    $display("Test data line could not be parsed: %s", line);
                    errors++;
                    continue;
                end

                bundle.rd_we       = rd_we;
                bundle.rd_addr     = rd_addr;
                bundle.rd_mem_data = rd_data;
                bundle.mem_addr    = addr;
                bundle.mem_op      = mem_stage_pkg::mem_op_t'(op);
                bundle.csr.we      = cwe;
                bundle.csr.waddr   = caddr;
                bundle.csr.wdata   = cdata;
                // Bubbles get random values in fields nobody looks at.
                if (!rd_we && !op[4] && !cwe) begin
                    bundle.rd_addr     = 5'($urandom);
                    bundle.rd_mem_data = $urandom;
                    bundle.mem_addr    = $urandom;
                    bundle.csr.waddr   = 12'($urandom);
                    bundle.csr.wdata   = $urandom;
                end

                @(posedge clk);
                ex_i    <= bundle;
                stall_i <= st;
                flush_i <= fl;

                if (wb_off > 0 && cyc + wb_off < MAX_CYC) begin
                    exp_wb_v[cyc + wb_off]    = 1'b1;
                    exp_wb[cyc + wb_off]      = '{e_wb_we, e_wb_addr, e_wb_data};
                    exp_wb_test[cyc + wb_off] = test;
                    test_last[test] = (cyc + wb_off > test_last[test]) ?
                                      cyc + wb_off : test_last[test];
                    last_slot = (cyc + wb_off > last_slot) ? cyc + wb_off : last_slot;
                end
                if (csr_off > 0 && cyc + csr_off < MAX_CYC) begin
                    exp_csr_v[cyc + csr_off]    = 1'b1;
                    exp_csr[cyc + csr_off]      = '{e_cwe, e_caddr, e_cdata};
                    exp_csr_test[cyc + csr_off] = test;
                    test_last[test] = (cyc + csr_off > test_last[test]) ?
                                      cyc + csr_off : test_last[test];
                    last_slot = (cyc + csr_off > last_slot) ? cyc + csr_off : last_slot;
                end
                test_used[test] = 1'b1;

                @(negedge clk);
                check_cycle(cyc);
                cyc++;
            end
            $fclose(fd);

            // Let instructions still in flight reach the outputs.
            guard = 0;
            while (cyc <= last_slot && guard < DRAIN_LIMIT) begin
                @(posedge clk);
                ex_i    <= '0;
                stall_i <= '0;
                flush_i <= '0;
                @(negedge clk);
                check_cycle(cyc);
                cyc++;
                guard++;
            end

            if (cyc <= last_slot) begin
                $display("Timed out waiting for the remaining expected results");
                $display("SIMULATION FAILED");
                $finish;
            end else begin
                $display("Tests passed: %0d, tests failed: %0d, check errors: %0d",
                         tests_passed, tests_failed, errors);
                if (errors == 0 && tests_failed == 0) begin
                    $display("SIMULATION PASSED");
                end else begin
                    $display("SIMULATION FAILED");
                end
                $finish;
            end
        end
    end

endmodule

//--- mem_stage.f
verilog/mem_stage_pkg.sv
verilog/ex_ls.sv
verilog/lsu.sv
verilog/dmem.sv
verilog/ls_wb.sv
verilog/mem_stage.sv
dv/tb_mem_stage.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the memory-stage testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_mem_stage \
    -f mem_stage.f --Mdir obj_dir -o tb_mem_stage
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_mem_stage > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "SIMULATION PASSED" sim.log; then
    exit 0
else
    exit 1
fi

//--- verilog/dmem.sv
`timescale 1ns/1ps

module dmem #(
    parameter int DEPTH_WORDS = 256
) (
    input  logic                           clk,
    input  mem_stage_pkg::mem_req_t        req_i,
    output logic [mem_stage_pkg::XLEN-1:0] rdata_o
);

    localparam int IDX_W = (DEPTH_WORDS > 1) ? $clog2(DEPTH_WORDS) : 1;
    localparam int LANES = mem_stage_pkg::XLEN / 8;

    logic [mem_stage_pkg::XLEN-1:0] mem_q [DEPTH_WORDS];
    logic [mem_stage_pkg::XLEN-1:0] rdata_q;
    logic [IDX_W-1:0]               idx;

    // Word address wraps around the array.
    assign idx = IDX_W'(req_i.addr % DEPTH_WORDS);

    always_ff @(posedge clk) begin
        if (req_i.en) begin
            if (req_i.we) begin
                for (int i = 0; i < LANES; i++) begin
                    if (req_i.be[i]) begin
                        mem_q[idx][8*i +: 8] <= req_i.wdata[8*i +: 8];
                    end
                end
            end else begin
                rdata_q <= mem_q[idx];
            end
        end
    end

    assign rdata_o = rdata_q;

endmodule

//--- verilog/ex_ls.sv
`timescale 1ns/1ps

module ex_ls (
    input  logic                  clk,
    input  logic                  reset_i,

    // From execute.
    input  mem_stage_pkg::ex_ls_t ex_i,

    // From pipeline controller.
    input  logic [5:0]            stall_i,
    input  logic [4:0]            flush_i,

    // To load/store unit and write-back register.
    output mem_stage_pkg::ex_ls_t ls_o
);

    logic                  clr;
    logic                  load;
    mem_stage_pkg::ex_ls_t ls_q;

    // Bubble when this stage holds but the next one moves on.
    assign clr  = (stall_i[3] & ~stall_i[4]) | flush_i[3];
    assign load = ~stall_i[3];

    // Clear wins over load; a zeroed bundle has every enable low.
    always_ff @(posedge clk) begin
        if (reset_i) begin
            ls_q <= '0;
        end else if (clr) begin
            ls_q <= '0;
        end else if (load) begin
            ls_q <= ex_i;
        end
    end

    assign ls_o = ls_q;

endmodule

//--- verilog/ls_wb.sv
`timescale 1ns/1ps

module ls_wb (
    input  logic                           clk,
    input  logic                           reset_i,

    // From EX/LS and data RAM.
    input  mem_stage_pkg::ex_ls_t          ls_i,
    input  logic [mem_stage_pkg::XLEN-1:0] rdata_i,

    // From pipeline controller.
    input  logic [5:0]                     stall_i,
    input  logic [4:0]                     flush_i,

    // To register file.
    output mem_stage_pkg::wb_t             wb_o
);

    localparam int XLEN = mem_stage_pkg::XLEN;

    logic                                clr;
    logic                                load;
    logic                                rd_we_q;
    mem_stage_pkg::mem_op_t              mem_op_q;
    logic [mem_stage_pkg::REG_ADDR_W-1:0] rd_addr_q;
    logic [XLEN-1:0]                     rd_mem_data_q;
    logic [1:0]                          offset_q;
    logic [XLEN-1:0]                     shifted;
    logic [XLEN-1:0]                     load_val;
    logic                                is_load;

    assign clr  = (stall_i[4] & ~stall_i[5]) | flush_i[4];
    assign load = ~stall_i[4];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            rd_we_q  <= 1'b0;
            mem_op_q <= '0;
        end else if (clr) begin
            rd_we_q  <= 1'b0;
            mem_op_q <= '0;
        end else if (load) begin
            rd_we_q  <= ls_i.rd_we;
            mem_op_q <= ls_i.mem_op;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            rd_addr_q     <= ls_i.rd_addr;
            rd_mem_data_q <= ls_i.rd_mem_data;
            offset_q      <= ls_i.mem_addr[1:0];
        end
    end

    // Bring the addressed lane down to bit 0.
    assign shifted = rdata_i >> {offset_q, 3'b000};
    assign is_load = mem_op_q.mem_en & ~mem_op_q.mem_we;

    always_comb begin
        case (mem_op_q.mem_size)
            mem_stage_pkg::MEM_BYTE: begin
                load_val = {{(XLEN-8){shifted[7] & ~mem_op_q.mem_unsigned}}, shifted[7:0]};
            end
            mem_stage_pkg::MEM_HALF: begin
                load_val = {{(XLEN-16){shifted[15] & ~mem_op_q.mem_unsigned}}, shifted[15:0]};
            end
            default: begin
                load_val = rdata_i;
            end
        endcase
    end

    assign wb_o.we   = rd_we_q;
    assign wb_o.addr = rd_addr_q;
    assign wb_o.data = is_load ? load_val : rd_mem_data_q;

endmodule

//--- verilog/lsu.sv
`timescale 1ns/1ps

module lsu (
    // Latched bundle from EX/LS.
    input  logic [5:0]              stall_i,
    input  mem_stage_pkg::ex_ls_t   ls_i,

    // To data RAM.
    output mem_stage_pkg::mem_req_t req_o
);

    logic [1:0]                     offset;
    logic [3:0]                     be;
    logic [mem_stage_pkg::XLEN-1:0] wdata;
    logic [mem_stage_pkg::XLEN-1:0] store_val;

    assign offset    = ls_i.mem_addr[1:0];
    assign store_val = ls_i.rd_mem_data;

    // Byte enables from size and byte offset.
    always_comb begin
        case (ls_i.mem_op.mem_size)
            mem_stage_pkg::MEM_BYTE: begin
                be = 4'b0001 << offset;
            end
            mem_stage_pkg::MEM_HALF: begin
                be = offset[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                be = 4'b1111;
            end
        endcase
    end

    // Replicate narrow store data so every enabled lane carries it.
    always_comb begin
        case (ls_i.mem_op.mem_size)
            mem_stage_pkg::MEM_BYTE: begin
                wdata = {4{store_val[7:0]}};
            end
            mem_stage_pkg::MEM_HALF: begin
                wdata = {2{store_val[15:0]}};
            end
            default: begin
                wdata = store_val;
            end
        endcase
    end

    // No access while WB holds, so its read word stays put.
    assign req_o.en    = ls_i.mem_op.mem_en & ~stall_i[4];
    assign req_o.we    = ls_i.mem_op.mem_en & ls_i.mem_op.mem_we;
    assign req_o.be    = be;
    assign req_o.addr  = {2'b00, ls_i.mem_addr[mem_stage_pkg::MEM_ADDR_W-1:2]};
    assign req_o.wdata = wdata;

endmodule

//--- verilog/mem_stage.sv
`timescale 1ns/1ps

module mem_stage #(
    parameter int DMEM_DEPTH_WORDS = 256
) (
    input  logic                   clk,
    input  logic                   reset_i,

    // From execute.
    input  mem_stage_pkg::ex_ls_t  ex_i,

    // From pipeline controller.
    input  logic [5:0]             stall_i,
    input  logic [4:0]             flush_i,

    // To register file and CSR file.
    output mem_stage_pkg::wb_t     wb_o,
    output mem_stage_pkg::csr_wr_t csr_wr_o
);

    mem_stage_pkg::ex_ls_t          ls_q;
    mem_stage_pkg::mem_req_t        mem_req;
    logic [mem_stage_pkg::XLEN-1:0] rdata;

    ex_ls u_ex_ls (
        .clk     (clk),
        .reset_i (reset_i),
        .ex_i    (ex_i),
        .stall_i (stall_i),
        .flush_i (flush_i),
        .ls_o    (ls_q)
    );

    lsu u_lsu (
        .stall_i (stall_i),
        .ls_i    (ls_q),
        .req_o   (mem_req)
    );

    dmem #(
        .DEPTH_WORDS (DMEM_DEPTH_WORDS)
    ) u_dmem (
        .clk     (clk),
        .req_i   (mem_req),
        .rdata_o (rdata)
    );

    ls_wb u_ls_wb (
        .clk     (clk),
        .reset_i (reset_i),
        .ls_i    (ls_q),
        .rdata_i (rdata),
        .stall_i (stall_i),
        .flush_i (flush_i),
        .wb_o    (wb_o)
    );

    // CSR write leaves straight from the EX/LS register.
    assign csr_wr_o = ls_q.csr;

endmodule

//--- verilog/mem_stage_pkg.sv
package mem_stage_pkg;

    // Datapath widths.
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int CSR_ADDR_W = 12;
    localparam int MEM_ADDR_W = 32;

    // Access size of a load or store.
    typedef enum logic [1:0] {
        MEM_BYTE = 2'b00,
        MEM_HALF = 2'b01,
        MEM_WORD = 2'b10
    } mem_size_e;

    // Memory part of the instruction, 5 bits.
    typedef struct packed {
        logic      mem_en;
        logic      mem_we;
        mem_size_e mem_size;
        logic      mem_unsigned;
    } mem_op_t;

    // CSR write, 45 bits.
    typedef struct packed {
        logic                  we;
        logic [CSR_ADDR_W-1:0] waddr;
        logic [XLEN-1:0]       wdata;
    } csr_wr_t;

    // Register write-back, 38 bits.
    typedef struct packed {
        logic                  we;
        logic [REG_ADDR_W-1:0] addr;
        logic [XLEN-1:0]       data;
    } wb_t;

    // Bundle handed over by execute, 120 bits.
    typedef struct packed {
        logic                  rd_we;
        logic [REG_ADDR_W-1:0] rd_addr;
        logic [XLEN-1:0]       rd_mem_data;  // ALU result, or store data
        logic [MEM_ADDR_W-1:0] mem_addr;
        mem_op_t               mem_op;
        csr_wr_t               csr;
    } ex_ls_t;

    // Data RAM request, 70 bits. Address is a word address.
    typedef struct packed {
        logic                  en;
        logic                  we;
        logic [3:0]            be;
        logic [MEM_ADDR_W-1:0] addr;
        logic [XLEN-1:0]       wdata;
    } mem_req_t;

endpackage
